// ==== sim.f ====
acp_regs_pkg.sv
acp_synth_pkg.sv
acp_reg_file.sv
acp_note_tick.sv
acp_tone_channel.sv
acp_mixer.sv
acp.sv
tb_acp.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the acp testbench with Verilator
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert --top-module tb_acp -f sim.f -o sim_tb_acp > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
	cat build.log
	echo "build failed with status $status"
	exit 1
fi

./obj_dir/sim_tb_acp > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q '\*\* FAIL \*\*' sim.log; then
	exit 1
fi
exit 0

// ==== tb_acp.sv ====
`timescale 1ns/1ps

module tb_acp;

	// note tick every 8 clocks in simulation
	localparam int tick_cycles = 8;
	localparam int ack_limit = 20;
	// square at level 15, volume 3, summed and times four
	localparam logic [7:0] square_peak = 8'(15 * 4);

	logic clk50MHz;
	logic reset;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	logic [acp_regs_pkg::adr_width-1:0] wb_adr;
	logic [acp_regs_pkg::bus_width-1:0] wb_dat_w;
	logic [acp_regs_pkg::bus_width-1:0] wb_dat_r;
	logic wb_ack;
	logic [acp_synth_pkg::sample_width-1:0] audio_out;

	// which checks are armed
	bit chk_idle;
	bit chk_read;
	bit chk_mute;
	bit chk_square;
	bit chk_silent;
	logic [acp_regs_pkg::bus_width-1:0] exp_dat;

	logic [31:0] lcg_state;
	logic [10:0] shadow [8];
	int err_count;
	int err_mark;
	int tests_ok;
	int tests_bad;

	acp #(.note_div(tick_cycles)) i_dut
	(
		.clk50MHz (clk50MHz),
		.reset    (reset),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_dat_w (wb_dat_w),
		.wb_dat_r (wb_dat_r),
		.wb_ack   (wb_ack),
		.audio_out(audio_out)
	);

	initial
	begin
		clk50MHz = 1'b0;
		forever #10 clk50MHz = ~clk50MHz;
	end

	//////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////
	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function void note_failure(input string msg);
		$display("[FAIL] %0t: %s", $time, msg);
		err_count++;
	endfunction

	// one Wishbone classic transfer, stb held until ack
	task automatic bus_cycle(input logic we, input logic [2:0] adr, input logic [15:0] dat);
		int waited;
		waited = 0;
		@(posedge clk50MHz);
		wb_cyc   <= 1'b1;
		wb_stb   <= 1'b1;
		wb_we    <= we;
		wb_adr   <= adr;
		wb_dat_w <= dat;
		@(negedge clk50MHz);
		while (!wb_ack && waited < ack_limit)
		begin
			@(negedge clk50MHz);
			waited++;
		end
		if (!wb_ack)
		begin
			$display("timeout: no ack from the bus at address %0d after %0d cycles",
				adr, ack_limit);
			err_count++;
		end
		@(posedge clk50MHz);
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we  <= 1'b0;
	endtask

	task automatic write_reg(input logic [2:0] adr, input logic [10:0] val);
		bus_cycle(1'b1, adr, {5'd0, val});
	endtask

	task automatic read_reg(input logic [2:0] adr);
		bus_cycle(1'b0, adr, 16'd0);
	endtask

	// note register word: length, volume, note index
	function automatic logic [10:0] note_word(input logic [2:0] len, input logic [1:0] vol,
		input logic [5:0] idx);
		return {len, vol, idx};
	endfunction

	task automatic wait_audio(input logic [7:0] val, input int limit);
		int waited;
		waited = 0;
		@(negedge clk50MHz);
		while (audio_out != val && waited < limit)
		begin
			@(negedge clk50MHz);
			waited++;
		end
		if (audio_out != val)
		begin
			$display("timeout: audio_out never reached %0d within %0d cycles", val, limit);
			err_count++;
		end
	endtask

	// wait for a run of zero samples longer than any low phase
	task automatic wait_quiet(input int run, input int limit);
		int waited;
		int zeros;
		waited = 0;
		zeros = 0;
		while (zeros < run && waited < limit)
		begin
			@(negedge clk50MHz);
			waited++;
			if (audio_out == 8'd0)
				zeros++;
			else
				zeros = 0;
		end
		if (zeros < run)
		begin
			$display("timeout: audio_out did not fall silent within %0d cycles", limit);
			err_count++;
		end
	endtask

	task automatic test_done(input string name);
		if (err_count == err_mark)
		begin
			$display("test %s: ok", name);
			tests_ok++;
		end
		else
		begin
			$display("test %s: failed with %0d errors", name, err_count - err_mark);
			tests_bad++;
		end
		err_mark = err_count;
	endtask

	//////////////////////////////////////////////////
	// checks
	//////////////////////////////////////////////////
	a_idle: assert property (@(posedge clk50MHz) disable iff (reset)
		chk_idle |-> (audio_out == 8'd0 && !wb_ack))
		else note_failure("output or ack active before the first transfer");
	// ack in the cycle after the request
	a_ack_next: assert property (@(posedge clk50MHz) disable iff (reset)
		(wb_cyc && wb_stb && !wb_ack) |=> wb_ack)
		else note_failure("no ack one cycle after stb");
	a_ack_once: assert property (@(posedge clk50MHz) disable iff (reset)
		wb_ack |=> !wb_ack)
		else note_failure("ack held for two cycles");
	a_readback: assert property (@(posedge clk50MHz) disable iff (reset)
		(chk_read && wb_ack) |-> wb_dat_r == exp_dat)
		else note_failure($sformatf("read data %h, expected %h", wb_dat_r, exp_dat));
	a_muted: assert property (@(posedge clk50MHz) disable iff (reset)
		chk_mute |-> audio_out == 8'd0)
		else note_failure("sound with all volumes at zero");
	a_square: assert property (@(posedge clk50MHz) disable iff (reset)
		chk_square |-> (audio_out == 8'd0 || audio_out == square_peak))
		else note_failure($sformatf("square in hold gave %0d", audio_out));
	a_silent: assert property (@(posedge clk50MHz) disable iff (reset)
		chk_silent |-> audio_out == 8'd0)
		else note_failure("sound after the note ended");
	// four voices of at most 15, times four
	a_range: assert property (@(posedge clk50MHz) disable iff (reset)
		(audio_out[1:0] == 2'b00 && audio_out <= 8'd240))
		else note_failure($sformatf("sample %0d off grid or above 240", audio_out));

	//////////////////////////////////////////////////
	// stimulus
	//////////////////////////////////////////////////
	initial
	begin
		logic [31:0] r;
		lcg_state = 32'h52cd_ebd8;
		err_count = 0;
		err_mark = 0;
		tests_ok = 0;
		tests_bad = 0;
		exp_dat = '0;
		reset    <= 1'b1;
		wb_cyc   <= 1'b0;
		wb_stb   <= 1'b0;
		wb_we    <= 1'b0;
		wb_adr   <= '0;
		wb_dat_w <= '0;
		repeat (3) @(posedge clk50MHz);
		reset <= 1'b0;

		// quiet bus and output after reset
		@(posedge clk50MHz);
		chk_idle = 1'b1;
		repeat (10) @(negedge clk50MHz);
		chk_idle = 1'b0;
		test_done("reset state");

		// random write then readback on all eight registers
		for (int a = 0; a < 8; a++)
		begin
			r = lcg_next();
			shadow[a] = r[26:16];
			write_reg(3'(a), shadow[a]);
		end
		for (int a = 0; a < 8; a++)
		begin
			exp_dat = {5'd0, shadow[a]};
			chk_read = 1'b1;
			read_reg(3'(a));
			chk_read = 1'b0;
		end
		test_done("register readback");

		// silence every voice first, then key many random notes
		for (int c = 0; c < 4; c++)
			write_reg(3'(2 * c), note_word(3'd0, 2'd0, 6'd0));
		@(posedge clk50MHz);
		chk_mute = 1'b1;
		for (int k = 0; k < 12; k++)
		begin
			r = lcg_next();
			write_reg(3'(2 * (k % 4) + 1), r[26:16]);
			r = lcg_next();
			write_reg(3'(2 * (k % 4)), note_word(r[18:16], 2'd0, r[29:24]));
			repeat (30) @(negedge clk50MHz);
		end
		chk_mute = 1'b0;
		test_done("muted voices");

		// ch0 square, 4/8 duty, note 59 is 15 clocks per half step
		write_reg(3'd1, 11'h020);
		write_reg(3'd0, note_word(3'd7, 2'd3, 6'd59));
		wait_audio(square_peak, 40 * tick_cycles);
		chk_square = 1'b1;
		wait_audio(8'd0, 200);
		wait_audio(square_peak, 200);
		chk_square = 1'b0;
		test_done("square in hold");

		// shortest note: 15 up, 4 hold, 15 down
		write_reg(3'd0, note_word(3'd0, 2'd3, 6'd59));
		wait_quiet(130, 40 * tick_cycles + 130);
		chk_silent = 1'b1;
		repeat (200) @(negedge clk50MHz);
		chk_silent = 1'b0;
		test_done("note end");

		// all voices at random settings, range check runs throughout
		for (int c = 0; c < 4; c++)
		begin
			r = lcg_next();
			write_reg(3'(2 * c + 1), r[26:16]);
			r = lcg_next();
			write_reg(3'(2 * c), r[26:16]);
		end
		repeat (600) @(negedge clk50MHz);
		test_done("full mix range");

		$display("tests ok: %0d, tests failed: %0d, errors: %0d", tests_ok, tests_bad,
			err_count);
		if (tests_bad == 0 && err_count == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

// ==== acp.sv ====
`timescale 1ns/1ps

module acp
#(
	parameter int note_div = acp_synth_pkg::note_div_default
)
(
	input  logic clk50MHz,
	input  logic reset,
	input  logic wb_cyc,
	input  logic wb_stb,
	input  logic wb_we,
	input  logic [acp_regs_pkg::adr_width-1:0] wb_adr,
	input  logic [acp_regs_pkg::bus_width-1:0] wb_dat_w,
	output logic [acp_regs_pkg::bus_width-1:0] wb_dat_r,
	output logic wb_ack,
	output logic [acp_synth_pkg::sample_width-1:0] audio_out
);

	logic [3:0] key_on;
	logic [5:0] note [4];
	logic [1:0] vol [4];
	logic [2:0] len [4];
	logic [1:0] atk [4];
	logic [1:0] dec [4];
	logic [1:0] sel [4];
	logic note_tick;
	logic [acp_synth_pkg::wave_width-1:0] wave [4];

	//////////////////////////////////////////////////
	// host registers and note clock
	//////////////////////////////////////////////////
	acp_reg_file u_reg_file
	(
		.clk50MHz (clk50MHz),
		.reset    (reset),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_dat_w (wb_dat_w),
		.wb_dat_r (wb_dat_r),
		.wb_ack   (wb_ack),
		.key_on   (key_on),
		.note     (note),
		.vol      (vol),
		.len      (len),
		.atk      (atk),
		.dec      (dec),
		.sel      (sel)
	);

	acp_note_tick #(.div(note_div)) u_note_tick
	(
		.clk50MHz  (clk50MHz),
		.reset     (reset),
		.note_tick (note_tick)
	);

	//////////////////////////////////////////////////
	// voices: square, square, triangle, noise
	//////////////////////////////////////////////////
	for (genvar i = 0; i < 4; i++)
	begin : g_ch
		acp_tone_channel
		#(
			.kind(i < 2 ? acp_synth_pkg::wave_square :
				(i == 2 ? acp_synth_pkg::wave_triangle : acp_synth_pkg::wave_noise))
		) u_channel
		(
			.clk50MHz  (clk50MHz),
			.reset     (reset),
			.note_tick (note_tick),
			.key_on    (key_on[i]),
			.note      (note[i]),
			.len       (len[i]),
			.atk       (atk[i]),
			.dec       (dec[i]),
			.sel       (sel[i]),
			.wave      (wave[i])
		);
	end

	acp_mixer u_mixer
	(
		.clk50MHz  (clk50MHz),
		.reset     (reset),
		.wave0     (wave[0]),
		.wave1     (wave[1]),
		.wave2     (wave[2]),
		.wave3     (wave[3]),
		.vol0      (vol[0]),
		.vol1      (vol[1]),
		.vol2      (vol[2]),
		.vol3      (vol[3]),
		.audio_out (audio_out)
	);

endmodule

// ==== acp_mixer.sv ====
`timescale 1ns/1ps

module acp_mixer
(
	input  logic clk50MHz,
	input  logic reset,
	input  logic [acp_synth_pkg::wave_width-1:0] wave0,
	input  logic [acp_synth_pkg::wave_width-1:0] wave1,
	input  logic [acp_synth_pkg::wave_width-1:0] wave2,
	input  logic [acp_synth_pkg::wave_width-1:0] wave3,
	input  logic [1:0] vol0,
	input  logic [1:0] vol1,
	input  logic [1:0] vol2,
	input  logic [1:0] vol3,
	output logic [acp_synth_pkg::sample_width-1:0] audio_out
);

	logic [acp_synth_pkg::wave_width-1:0] w [4];
	logic [1:0] v [4];
	logic [acp_synth_pkg::wave_width-1:0] scaled [4];
	logic [acp_synth_pkg::sample_width-3:0] sum;

	assign w = '{wave0, wave1, wave2, wave3};
	assign v = '{vol0, vol1, vol2, vol3};

	// volume as a shift: mute, /4, /2, full
	always_comb
	begin
		sum = '0;
		for (int i = 0; i < 4; i++)
		begin
			case (v[i])
				2'd0:    scaled[i] = '0;
				2'd1:    scaled[i] = w[i] >> 2;
				2'd2:    scaled[i] = w[i] >> 1;
				default: scaled[i] = w[i];
			endcase
			sum = sum + 6'(scaled[i]);
		end
	end

	// times four into the 8-bit sample
	always_ff @(posedge clk50MHz)
	begin
		if (reset)
			audio_out <= '0;
		else
			audio_out <= {sum, 2'b00};
	end

	// four full-scale voices peak at 240
	a_out_max: assert property (@(posedge clk50MHz) disable iff (reset)
		audio_out <= 8'd240);

endmodule

// ==== acp_tone_channel.sv ====
`timescale 1ns/1ps

module acp_tone_channel
#(
	parameter acp_synth_pkg::wave_kind_e kind = acp_synth_pkg::wave_square
)
(
	input  logic clk50MHz,
	input  logic reset,
	input  logic note_tick,
	input  logic key_on,
	input  logic [5:0] note,
	input  logic [2:0] len,
	input  logic [1:0] atk,
	input  logic [1:0] dec,
	input  logic [1:0] sel,
	output logic [acp_synth_pkg::wave_width-1:0] wave
);

	logic [acp_synth_pkg::note_base_width-1:0] half_period;
	logic [acp_synth_pkg::note_base_width-1:0] cnt;
	logic [3:0] semi;
	logic [2:0] octave;
	logic [4:0] phase;
	logic [14:0] lfsr;
	logic fb;
	logic [2:0] duty;
	logic sq_bit;
	logic [3:0] ramp;
	logic [7:0] tri_prod;
	acp_synth_pkg::env_state_e state;
	logic [acp_synth_pkg::wave_width-1:0] level;
	logic [1:0] pace;
	logic [4:0] hold_cnt;
	logic [4:0] hold_last;

	//////////////////////////////////////////////////
	// pitch and phase
	//////////////////////////////////////////////////
	assign semi        = 4'(note % 6'd12);
	assign octave      = 3'(note / 6'd12);
	assign half_period = acp_synth_pkg::note_base[semi] >> octave;
	// short loop on nonzero select
	assign fb = lfsr[0] ^ ((sel != 2'd0) ? lfsr[6] : lfsr[1]);

	always_ff @(posedge clk50MHz)
	begin
		if (reset)
		begin
			cnt   <= '0;
			phase <= '0;
			lfsr  <= 15'd1;
		end
		else if (key_on)
		begin
			cnt   <= '0;
			phase <= '0;
		end
		else if (cnt == '0)
		begin
			cnt   <= half_period - 1'b1;
			phase <= phase + 5'd1;
			lfsr  <= {fb, lfsr[14:1]};
		end
		else
		begin
			cnt <= cnt - 1'b1;
		end
	end

	// duty in eighths: 1, 2, 4, 6
	always_comb
	begin
		case (sel)
			2'd0:    duty = 3'd1;
			2'd1:    duty = 3'd2;
			2'd2:    duty = 3'd4;
			default: duty = 3'd6;
		endcase
	end

	assign sq_bit = (phase[2:0] < duty);
	// up on first half, down on second
	assign ramp     = phase[4] ? ~phase[3:0] : phase[3:0];
	assign tri_prod = {4'd0, level} * {4'd0, ramp};

	//////////////////////////////////////////////////
	// envelope
	//////////////////////////////////////////////////
	assign hold_last = 5'((int'(len) + 1) * acp_synth_pkg::len_unit - 1);

	always_ff @(posedge clk50MHz)
	begin
		if (reset)
		begin
			state    <= acp_synth_pkg::env_idle;
			level    <= '0;
			pace     <= '0;
			hold_cnt <= '0;
		end
		else if (key_on)
		begin
			state    <= acp_synth_pkg::env_attack;
			level    <= '0;
			pace     <= '0;
			hold_cnt <= '0;
		end
		else if (note_tick)
		begin
			case (state)
				acp_synth_pkg::env_attack:
				begin
					// one step per atk+1 ticks
					if (pace == atk)
					begin
						pace  <= '0;
						level <= level + 1'b1;
						if (level == 4'd14)
							state <= acp_synth_pkg::env_hold;
					end
					else
						pace <= pace + 2'd1;
				end
				acp_synth_pkg::env_hold:
				begin
					if (hold_cnt == hold_last)
					begin
						hold_cnt <= '0;
						state    <= acp_synth_pkg::env_decay;
					end
					else
						hold_cnt <= hold_cnt + 5'd1;
				end
				acp_synth_pkg::env_decay:
				begin
					if (pace == dec)
					begin
						pace  <= '0;
						level <= level - 1'b1;
						// last step ends the note
						if (level == 4'd1)
							state <= acp_synth_pkg::env_idle;
					end
					else
						pace <= pace + 2'd1;
				end
				default: ;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// output shaping
	//////////////////////////////////////////////////
	always_comb
	begin
		case (kind)
			acp_synth_pkg::wave_square:   wave = sq_bit ? level : '0;
			acp_synth_pkg::wave_triangle: wave = tri_prod[7:4];
			default:                      wave = lfsr[0] ? level : '0;
		endcase
	end

	// silent outside attack means the note is over
	a_silent_idle: assert property (@(posedge clk50MHz) disable iff (reset)
		(level == '0 && state != acp_synth_pkg::env_attack) |-> state == acp_synth_pkg::env_idle);

endmodule

// ==== acp_note_tick.sv ====
`timescale 1ns/1ps

module acp_note_tick
#(
	parameter int div = acp_synth_pkg::note_div_default
)
(
	input  logic clk50MHz,
	input  logic reset,
	output logic note_tick
);

	logic [31:0] cnt;

	// wrap at div-1, one-cycle enable on the wrap
	always_ff @(posedge clk50MHz)
	begin
		if (reset)
		begin
			cnt       <= '0;
			note_tick <= 1'b0;
		end
		else
		begin
			note_tick <= (cnt == div - 1);
			if (cnt == div - 1)
				cnt <= '0;
			else
				cnt <= cnt + 32'd1;
		end
	end

endmodule

// ==== acp_reg_file.sv ====
`timescale 1ns/1ps

module acp_reg_file
(
	input  logic clk50MHz,
	input  logic reset,
	input  logic wb_cyc,
	input  logic wb_stb,
	input  logic wb_we,
	input  logic [acp_regs_pkg::adr_width-1:0] wb_adr,
	input  logic [acp_regs_pkg::bus_width-1:0] wb_dat_w,
	output logic [acp_regs_pkg::bus_width-1:0] wb_dat_r,
	output logic wb_ack,
	output logic [3:0] key_on,
	output logic [5:0] note [4],
	output logic [1:0] vol [4],
	output logic [2:0] len [4],
	output logic [1:0] atk [4],
	output logic [1:0] dec [4],
	output logic [1:0] sel [4]
);

	// eight registers, channel pairs of note then effect
	logic [acp_regs_pkg::reg_width-1:0] regs [2**acp_regs_pkg::adr_width];
	logic xfer;
	acp_regs_pkg::reg_kind_e kind;

	// pending transfer not yet acked
	assign xfer = wb_cyc && wb_stb && !wb_ack;
	assign kind = acp_regs_pkg::reg_kind_e'(wb_adr[0]);

	//////////////////////////////////////////////////
	// bus side
	//////////////////////////////////////////////////
	always_ff @(posedge clk50MHz)
	begin
		if (reset)
		begin
			wb_ack <= 1'b0;
			key_on <= '0;
			for (int i = 0; i < 2**acp_regs_pkg::adr_width; i++)
			begin
				regs[i] <= '0;
			end
		end
		else
		begin
			wb_ack <= xfer;
			key_on <= '0;
			if (xfer && wb_we)
			begin
				regs[wb_adr] <= wb_dat_w[acp_regs_pkg::reg_width-1:0];
				// note write restarts that channel
				if (kind == acp_regs_pkg::reg_note)
				begin
					key_on[wb_adr[2:1]] <= 1'b1;
				end
			end
		end
	end

	// read data, zero-extended, valid with ack
	always_ff @(posedge clk50MHz)
	begin
		if (xfer)
		begin
			wb_dat_r <= {{(acp_regs_pkg::bus_width - acp_regs_pkg::reg_width){1'b0}},
				regs[wb_adr]};
		end
	end

	//////////////////////////////////////////////////
	// field split per channel
	//////////////////////////////////////////////////
	for (genvar i = 0; i < 4; i++)
	begin : g_field
		assign note[i] = regs[2*i][acp_regs_pkg::note_msb:acp_regs_pkg::note_lsb];
		assign vol[i]  = regs[2*i][acp_regs_pkg::vol_msb:acp_regs_pkg::vol_lsb];
		assign len[i]  = regs[2*i][acp_regs_pkg::len_msb:acp_regs_pkg::len_lsb];
		assign atk[i]  = regs[2*i+1][acp_regs_pkg::atk_msb:acp_regs_pkg::atk_lsb];
		assign dec[i]  = regs[2*i+1][acp_regs_pkg::dec_msb:acp_regs_pkg::dec_lsb];
		assign sel[i]  = regs[2*i+1][acp_regs_pkg::sel_msb:acp_regs_pkg::sel_lsb];
	end

	// single-cycle ack
	a_ack_single: assert property (@(posedge clk50MHz) disable iff (reset)
		wb_ack |=> !wb_ack);
	// ack only answers a request from the cycle before
	a_ack_req: assert property (@(posedge clk50MHz) disable iff (reset)
		wb_ack |-> $past(wb_cyc && wb_stb));

endmodule

// ==== acp_synth_pkg.sv ====
package acp_synth_pkg;

	//////////////////////////////////////////////////
	// voice kinds and envelope states
	//////////////////////////////////////////////////
	typedef enum logic [1:0]
	{
		wave_square   = 2'd0,
		wave_triangle = 2'd1,
		wave_noise    = 2'd2
	} wave_kind_e;

	typedef enum logic [1:0]
	{
		env_idle   = 2'd0,
		env_attack = 2'd1,
		env_hold   = 2'd2,
		env_decay  = 2'd3
	} env_state_e;

	//////////////////////////////////////////////////
	// pitch
	//////////////////////////////////////////////////
	localparam int note_base_width = 9;
	// lowest octave, one entry per semitone, counts of clk50MHz
	// higher octaves shift right by note / 12
	localparam logic [note_base_width-1:0] note_base [12] = '{
		9'd478, 9'd451, 9'd426, 9'd402,
		9'd379, 9'd358, 9'd338, 9'd319,
		9'd301, 9'd284, 9'd268, 9'd253
	};

	// note tick every this many clocks in hardware
	localparam int note_div_default = 97656;

	//////////////////////////////////////////////////
	// sample widths and length unit
	//////////////////////////////////////////////////
	// per-channel wave, also envelope level
	localparam int wave_width = 4;
	// mixed output
	localparam int sample_width = 8;
	// note ticks per step of the length field
	localparam int len_unit = 4;

endpackage

// ==== acp_regs_pkg.sv ====
package acp_regs_pkg;

	//////////////////////////////////////////////////
	// host bus geometry
	//////////////////////////////////////////////////
	localparam int bus_width = 16;
	// adr[2:1] channel, adr[0] note or effect
	localparam int adr_width = 3;
	// stored width of every channel register
	localparam int reg_width = 11;

	// note register fields
	localparam int note_lsb = 0;
	localparam int note_msb = 5;
	localparam int vol_lsb  = 6;
	localparam int vol_msb  = 7;
	localparam int len_lsb  = 8;
	localparam int len_msb  = 10;

	// effect register fields
	localparam int atk_lsb  = 0;
	localparam int atk_msb  = 1;
	localparam int dec_lsb  = 2;
	localparam int dec_msb  = 3;
	localparam int sel_lsb  = 4;
	localparam int sel_msb  = 5;
	// optA and optB only stored, no logic behind them
	localparam int opta_lsb = 6;
	localparam int opta_msb = 7;
	localparam int optb_lsb = 8;
	localparam int optb_msb = 9;

	// address bit 0
	typedef enum logic {reg_note = 1'b0, reg_effect = 1'b1} reg_kind_e;

endpackage
